// ==== tb.f ====
src/cache_pkg.sv
src/cache_tag_store.sv
src/cache_victim_lfsr.sv
src/cache_data_ram.sv
src/cache_ctrl_fsm.sv
src/cache_top.sv
testbench/cache_assertions.sv
testbench/cache_tb.sv

// ==== testbench/cache_tb.sv ====
//##########################################################################
// cache_tb: clock and reset, sparse memory model with random stalls,
// LFSR stimulus, directed cache tests and the value checker
//##########################################################################
`default_nettype none

module cache_tb;

    localparam int TESTS_RUN  = 10;                   // five tests in each of two passes
    localparam int MAX_ACCESS = 10;                   // accesses in the longest test
    localparam int WORST_MISS = 2 * (3 * 8 + 8) + 8;  // stalled write-back plus refill
    localparam int TIMEOUT    = TESTS_RUN * MAX_ACCESS * WORST_MISS;
    localparam cache_pkg::addr_t LINE_A = {22'h00123, 4'd1, 6'd0};
    localparam cache_pkg::addr_t LINE_B = {22'h00245, 4'd2, 6'd0};

    logic clk = 1'b0;
    logic rst;
    cache_pkg::addr_t cpu_addr;
    logic             cpu_rd;
    logic             cpu_wr;
    cache_pkg::word_t cpu_w_data;
    cache_pkg::strb_t cpu_w_strb;
    cache_pkg::word_t cpu_r_data;
    logic             cpu_r_valid;
    logic             cpu_w_ready;
    logic             cache_busy;
    cache_pkg::addr_t mem_w_addr;
    logic             mem_w_valid;
    cache_pkg::word_t mem_w_data;
    logic             mem_w_ready;
    cache_pkg::addr_t mem_r_addr;
    logic             mem_r_ready;
    logic             mem_r_valid;
    cache_pkg::word_t mem_r_data;

    logic [31:0]      data_rng;
    logic [31:0]      stall_rng;
    logic             stall_en;
    logic             stall;
    logic             last_beat;
    logic [7:0]       victim_lfsr;   // tracks the cache's replacement LFSR
    int               cycles = 0;
    int               rd_beat;
    int               wb_beat;
    int               r_ready_seen;
    int               idle_refill_cycles;  // refill cycles with cache_busy low
    cache_pkg::word_t mem_store [cache_pkg::addr_t];
    cache_pkg::word_t cpu_view [cache_pkg::addr_t];  // what the CPU should read back
    cache_pkg::addr_t rf_log[$];
    cache_pkg::addr_t wb_addr_log[$];
    cache_pkg::word_t wb_data_log[$];

    cache_top #(
        .VICTIM_SEED(8'd1)
    ) i_dut (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
    endfunction

    function automatic logic [7:0] lfsr8_step(logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    function automatic cache_pkg::word_t random_word();
        cache_pkg::word_t v;
        v = '0;
        for (int i = 0; i < 64; i++) begin
            data_rng = lfsr_step(data_rng);
            v = {v[62:0], data_rng[0]};
        end
        return v;
    endfunction

    function automatic logic stall_cycle();
        logic a;
        stall_rng = lfsr_step(stall_rng);
        a = stall_rng[0];
        stall_rng = lfsr_step(stall_rng);
        return a & stall_rng[0];  // about one cycle in four
    endfunction

    function automatic cache_pkg::word_t fill_word(cache_pkg::addr_t a);
        return {a ^ 32'h6a09_e667, ~a};
    endfunction

    function automatic cache_pkg::word_t mem_word(cache_pkg::addr_t a);
        return mem_store.exists(a) ? mem_store[a] : fill_word(a);
    endfunction

    function automatic cache_pkg::word_t expected_word(cache_pkg::addr_t a);
        return cpu_view.exists(a) ? cpu_view[a] : fill_word(a);
    endfunction

    function automatic cache_pkg::word_t merge(cache_pkg::word_t old_w,
                                               cache_pkg::word_t new_w,
                                               cache_pkg::strb_t strb);
        cache_pkg::word_t m;
        m = old_w;
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) begin
                m[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return m;
    endfunction

    function automatic cache_pkg::addr_t evict_set_line(int i);
        return {22'h00300 + 22'(i), 4'd5, 6'd0};  // all in set 5
    endfunction

    // memory model counts beats from the pre-edge handshake values
    always @(posedge clk) begin
        if (rst) begin
            mem_r_valid <= 1'b0;
            mem_w_ready <= 1'b0;
            rd_beat = 0;
            wb_beat = 0;
        end else begin
            stall = stall_en && stall_cycle();
            if (mem_w_valid && mem_w_ready) begin
                mem_store[mem_w_addr + 8 * wb_beat] = mem_w_data;
                wb_addr_log.push_back(mem_w_addr);
                wb_data_log.push_back(mem_w_data);
                wb_beat = (wb_beat + 1) % 8;
            end
            last_beat = mem_r_valid && mem_r_ready && (rd_beat == 7);
            if (mem_r_valid && mem_r_ready) begin
                rd_beat = (rd_beat + 1) % 8;
            end
            if (last_beat) begin
                rf_log.push_back(mem_r_addr);  // one entry per full burst
            end
            if (mem_r_ready) begin
                r_ready_seen++;
            end
            if (mem_r_ready && !cache_busy) begin
                idle_refill_cycles++;
            end
            mem_r_valid <= mem_r_ready && !last_beat && !stall;
            mem_r_data  <= mem_word(mem_r_addr + 8 * rd_beat);
            mem_w_ready <= !stall;
        end
    end

    always @(negedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("timeout: tests still running after %0d cycles", TIMEOUT);
            $display("** FAIL **");
            $fatal(1);
        end else if (i_dut.i_assert.fail_count != 0) begin
            $display("a protocol assertion on the cache ports failed");
            $display("** FAIL **");
            $fatal(1);
        end
    end

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("** Error [%s] expected %h, actual %h", name, expected, actual);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        mem_store.delete();
        cpu_view.delete();
        victim_lfsr = 8'd1;
    endtask

    task automatic read_check(input string name, input cache_pkg::addr_t a);
        cache_pkg::word_t d;
        @(posedge clk);
        cpu_addr <= a;
        cpu_rd   <= 1'b1;
        @(negedge clk);
        while (!cpu_r_valid) begin
            @(negedge clk);
        end
        d = cpu_r_data;
        @(posedge clk);
        cpu_rd <= 1'b0;
        check(name, expected_word(a), d);
    endtask

    task automatic write_word(input cache_pkg::addr_t a, input cache_pkg::word_t data,
                              input cache_pkg::strb_t strb);
        cpu_view[a] = merge(expected_word(a), data, strb);
        @(posedge clk);
        cpu_addr   <= a;
        cpu_wr     <= 1'b1;
        cpu_w_data <= data;
        cpu_w_strb <= strb;
        @(negedge clk);
        while (!cpu_w_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        cpu_wr <= 1'b0;
    endtask

    task automatic cold_read_miss();
        @(negedge clk);
        check("cold_miss busy", 0, cache_busy);
        rf_log.delete();
        idle_refill_cycles = 0;
        read_check("cold_miss data", LINE_A + 8 * 3);
        check("cold_miss refills", 1, rf_log.size());
        check("cold_miss refill addr", LINE_A, rf_log[0]);
        check("cold_miss busy during refill", 0, idle_refill_cycles);
    endtask

    task automatic reread_line();
        r_ready_seen = 0;
        for (int w = 0; w < 8; w++) begin
            read_check("read_hit data", LINE_A + 8 * w);
        end
        check("read_hit mem_r_ready cycles", 0, r_ready_seen);
    endtask

    task automatic strobed_write_hit();
        rf_log.delete();
        write_word(LINE_A + 8 * 5, random_word(), 8'b1010_0110);
        read_check("write_hit merge", LINE_A + 8 * 5);
        check("write_hit refills", 0, rf_log.size());
    endtask

    task automatic write_miss_merge();
        rf_log.delete();
        write_word(LINE_B + 8 * 6, random_word(), 8'hf0);
        check("write_miss refills", 1, rf_log.size());
        check("write_miss refill addr", LINE_B, rf_log[0]);
        for (int w = 0; w < 8; w++) begin
            read_check("write_miss line", LINE_B + 8 * w);
        end
    endtask

    task automatic evict_dirty_line();
        cache_pkg::way_t  victim;
        cache_pkg::addr_t old_line;
        wb_addr_log.delete();
        wb_data_log.delete();
        for (int i = 0; i < 4; i++) begin
            write_word(evict_set_line(i) + 8 * i, random_word(), 8'h3c);  // fills way i
        end
        check("evict fill write-backs", 0, wb_addr_log.size());
        victim   = victim_lfsr[1:0];
        old_line = evict_set_line(victim);
        rf_log.delete();
        read_check("evict new tag", evict_set_line(4));
        victim_lfsr = lfsr8_step(victim_lfsr);  // refill into a full set
        check("evict write-back beats", 8, wb_addr_log.size());
        for (int w = 0; w < 8; w++) begin
            check("evict write-back addr", old_line, wb_addr_log[w]);
            check("evict write-back data", expected_word(old_line + 8 * w), wb_data_log[w]);
        end
        check("evict refill addr", evict_set_line(4), rf_log[0]);
        rf_log.delete();
        read_check("evict reread", old_line + 8 * victim);
        victim_lfsr = lfsr8_step(victim_lfsr);
        check("evict reread refill", old_line, rf_log[0]);
    endtask

    task automatic run_pass(input logic stalls);
        stall_en <= stalls;
        apply_reset();
        cold_read_miss();
        reread_line();
        strobed_write_hit();
        write_miss_merge();
        evict_dirty_line();
    endtask

    initial begin
        rst         = 1'b1;
        cpu_addr    = '0;
        cpu_rd      = 1'b0;
        cpu_wr      = 1'b0;
        cpu_w_data  = '0;
        cpu_w_strb  = '0;
        mem_w_ready = 1'b0;
        mem_r_valid = 1'b0;
        mem_r_data  = '0;
        stall_en    = 1'b0;
        data_rng    = 32'h6f07;
        stall_rng   = 32'h6f07;
        run_pass(1'b0);
        run_pass(1'b1);  // same tests under memory back-pressure
        if (i_dut.i_assert.fail_count == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("** FAIL **");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// ==== testbench/cache_assertions.sv ====
//##########################################################################
// cache_assertions: protocol checks on the CPU answer strobes and on the
// memory write and read handshakes, bound into cache_top
//##########################################################################
`default_nettype none

module cache_assertions (
    input wire logic             clk,
    input wire logic             rst,
    input wire logic             cpu_r_valid,
    input wire logic             cpu_w_ready,
    input wire logic             mem_w_valid,
    input wire logic             mem_w_ready,
    input wire cache_pkg::addr_t mem_w_addr,
    input wire cache_pkg::word_t mem_w_data,
    input wire logic             mem_r_ready
);

    int fail_count = 0;   // failed checks so far

    answers_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(cpu_r_valid && cpu_w_ready))
    else begin
        fail_count++;
        $error("cpu_r_valid and cpu_w_ready high in the same cycle");
    end

    // a pending write-back beat keeps its address and data
    write_beat_held: assert property (@(posedge clk) disable iff (rst)
        (mem_w_valid && !mem_w_ready) |=>
            (mem_w_valid && $stable(mem_w_addr) && $stable(mem_w_data)))
    else begin
        fail_count++;
        $error("write-back beat dropped or changed before mem_w_ready");
    end

    buses_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(mem_w_valid && mem_r_ready))
    else begin
        fail_count++;
        $error("mem_w_valid and mem_r_ready high in the same cycle");
    end

endmodule

bind cache_top cache_assertions i_assert (.*);

`default_nettype wire

// ==== src/cache_top.sv ====
//##########################################################################
// cache_top: 4 KB 4-way write-back data cache, CPU port and memory port,
// built from the controller, tag store, replacement LFSR and data array
//##########################################################################
`default_nettype none

module cache_top #(
    parameter logic [7:0] VICTIM_SEED = 8'd1
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire cache_pkg::addr_t cpu_addr,
    input  wire logic             cpu_rd,
    input  wire logic             cpu_wr,
    input  wire cache_pkg::word_t cpu_w_data,
    input  wire cache_pkg::strb_t cpu_w_strb,
    output cache_pkg::word_t      cpu_r_data,
    output logic                  cpu_r_valid,
    output logic                  cpu_w_ready,
    output logic                  cache_busy,
    output cache_pkg::addr_t      mem_w_addr,
    output logic                  mem_w_valid,
    output cache_pkg::word_t      mem_w_data,
    input  wire logic             mem_w_ready,
    output cache_pkg::addr_t      mem_r_addr,
    output logic                  mem_r_ready,
    input  wire logic             mem_r_valid,
    input  wire cache_pkg::word_t mem_r_data
);

    logic                 hit;
    logic                 set_full;
    logic                 victim_dirty;
    logic                 victim_step;
    logic                 tag_w_en;
    logic                 tag_w_dirty;
    logic                 ram_r_en;
    logic                 ram_w_en;
    cache_pkg::way_t      hit_way;
    cache_pkg::way_t      empty_way;
    cache_pkg::way_t      victim_way;
    cache_pkg::way_t      tag_w_way;
    cache_pkg::way_t      ram_way;
    cache_pkg::tag_t      lookup_tag;
    cache_pkg::tag_t      victim_tag;
    cache_pkg::index_t    lookup_index;
    cache_pkg::index_t    ram_index;
    cache_pkg::word_sel_t ram_word;
    cache_pkg::word_t     ram_w_data;
    cache_pkg::word_t     ram_r_data;
    cache_pkg::strb_t     ram_w_strb;

    assign cpu_r_data = ram_r_data;   // read hits and write-back beats share it
    assign mem_w_data = ram_r_data;

    cache_ctrl_fsm i_ctrl (
        .clk, .rst,
        .cpu_addr, .cpu_rd, .cpu_wr, .cpu_w_data, .cpu_w_strb,
        .cpu_r_valid, .cpu_w_ready, .cache_busy,
        .mem_w_addr, .mem_w_valid, .mem_w_ready,
        .mem_r_addr, .mem_r_ready, .mem_r_valid, .mem_r_data,
        .hit, .hit_way, .victim_dirty, .victim_tag, .victim_way,
        .lookup_tag, .lookup_index, .tag_w_en, .tag_w_way, .tag_w_dirty,
        .ram_way, .ram_index, .ram_word, .ram_r_en, .ram_w_en,
        .ram_w_data, .ram_w_strb,
        .victim_step
    );

    cache_tag_store i_tags (
        .clk, .rst,
        .lookup_tag, .lookup_index, .victim_way,
        .tag_w_en, .tag_w_way, .tag_w_dirty,
        .hit, .hit_way, .set_full, .empty_way,
        .victim_dirty, .victim_tag
    );

    cache_victim_lfsr #(
        .VICTIM_SEED(VICTIM_SEED)
    ) i_victim (
        .clk, .rst,
        .set_full, .empty_way, .victim_step,
        .victim_way
    );

    cache_data_ram i_data (
        .clk,
        .ram_way, .ram_index, .ram_word,
        .ram_r_en, .ram_w_en, .ram_w_data, .ram_w_strb,
        .ram_r_data
    );

endmodule

`default_nettype wire

// ==== src/cache_ctrl_fsm.sv ====
//##########################################################################
// cache_ctrl_fsm: request latch, hit / write-back / refill sequencing,
// burst beat counter, data array muxing and memory-side strobes
//##########################################################################
`default_nettype none

module cache_ctrl_fsm (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire cache_pkg::addr_t     cpu_addr,
    input  wire logic                 cpu_rd,
    input  wire logic                 cpu_wr,
    input  wire cache_pkg::word_t     cpu_w_data,
    input  wire cache_pkg::strb_t     cpu_w_strb,
    output logic                      cpu_r_valid,
    output logic                      cpu_w_ready,
    output logic                      cache_busy,
    output cache_pkg::addr_t          mem_w_addr,
    output logic                      mem_w_valid,
    input  wire logic                 mem_w_ready,
    output cache_pkg::addr_t          mem_r_addr,
    output logic                      mem_r_ready,
    input  wire logic                 mem_r_valid,
    input  wire cache_pkg::word_t     mem_r_data,
    input  wire logic                 hit,
    input  wire cache_pkg::way_t      hit_way,
    input  wire logic                 victim_dirty,
    input  wire cache_pkg::tag_t      victim_tag,
    input  wire cache_pkg::way_t      victim_way,
    output cache_pkg::tag_t           lookup_tag,
    output cache_pkg::index_t         lookup_index,
    output logic                      tag_w_en,
    output cache_pkg::way_t           tag_w_way,
    output logic                      tag_w_dirty,
    output cache_pkg::way_t           ram_way,
    output cache_pkg::index_t         ram_index,
    output cache_pkg::word_sel_t      ram_word,
    output logic                      ram_r_en,
    output logic                      ram_w_en,
    output cache_pkg::word_t          ram_w_data,
    output cache_pkg::strb_t          ram_w_strb,
    output logic                      victim_step
);

    cache_pkg::ctrl_state_t state_q;
    cache_pkg::addr_t       req_addr_q;
    cache_pkg::way_t        way_q;
    cache_pkg::word_sel_t   beat_q;
    logic                   rd_q;
    logic                   accepting;
    logic                   req;
    logic                   wb_beat;
    logic                   rf_beat;
    logic                   line_done;

    // the answer cycle still shows the old request on the cpu pins
    assign req       = (cpu_rd | cpu_wr) & ~cpu_r_valid & ~cpu_w_ready;
    assign accepting = ((state_q == cache_pkg::idle) || (state_q == cache_pkg::lookup_again)) && req;

    assign wb_beat   = (state_q == cache_pkg::write_back) && mem_w_valid && mem_w_ready;
    assign rf_beat   = (state_q == cache_pkg::refill) && mem_r_valid;
    assign line_done = rf_beat && (beat_q == '1);

    // look up the live address only while idle
    assign lookup_tag   = (state_q == cache_pkg::idle) ? cache_pkg::addr_tag(cpu_addr)
                                                       : cache_pkg::addr_tag(req_addr_q);
    assign lookup_index = (state_q == cache_pkg::idle) ? cache_pkg::addr_index(cpu_addr)
                                                       : cache_pkg::addr_index(req_addr_q);

    assign cache_busy  = (state_q != cache_pkg::idle);
    assign mem_r_ready = (state_q == cache_pkg::refill);
    assign mem_w_addr  = cache_pkg::line_addr(victim_tag, cache_pkg::addr_index(req_addr_q));
    assign mem_r_addr  = cache_pkg::line_addr(cache_pkg::addr_tag(req_addr_q),
                                              cache_pkg::addr_index(req_addr_q));

    assign tag_w_way   = way_q;
    assign tag_w_dirty = (state_q == cache_pkg::write_hit);
    assign tag_w_en    = (state_q == cache_pkg::write_hit) || line_done;
    assign victim_step = line_done;   // lfsr decides if the set was full

    assign ram_way   = way_q;
    assign ram_index = cache_pkg::addr_index(req_addr_q);
    always_comb begin
        if ((state_q == cache_pkg::read_hit) || (state_q == cache_pkg::write_hit)) begin
            ram_word = cache_pkg::addr_word(req_addr_q);
        end else begin
            ram_word = beat_q;  // bursts run word 0 to 7
        end
    end

    // one read per beat, issued while the bus is between beats
    assign ram_r_en = ((state_q == cache_pkg::read_hit) && !rd_q)
                   || ((state_q == cache_pkg::write_back) && !mem_w_valid);
    assign ram_w_en   = (state_q == cache_pkg::write_hit) || rf_beat;
    assign ram_w_data = (state_q == cache_pkg::refill) ? mem_r_data : cpu_w_data;
    assign ram_w_strb = (state_q == cache_pkg::refill) ? '1 : cpu_w_strb;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= cache_pkg::idle;
            beat_q      <= '0;
            rd_q        <= 1'b0;
            cpu_r_valid <= 1'b0;
            cpu_w_ready <= 1'b0;
            mem_w_valid <= 1'b0;
        end else begin
            rd_q        <= ram_r_en;
            cpu_r_valid <= 1'b0;
            cpu_w_ready <= 1'b0;
            // up the cycle after the array read, down once the beat is taken
            mem_w_valid <= (state_q == cache_pkg::write_back)
                        && (ram_r_en || (mem_w_valid && !mem_w_ready));
            if (wb_beat || rf_beat) begin
                beat_q <= beat_q + 3'd1;  // wraps to 0 after the last beat
            end
            case (state_q)
                cache_pkg::idle, cache_pkg::lookup_again: begin
                    if (!req) begin
                        state_q <= cache_pkg::idle;
                    end else if (hit) begin
                        state_q <= cpu_wr ? cache_pkg::write_hit : cache_pkg::read_hit;
                    end else if (victim_dirty) begin
                        state_q <= cache_pkg::write_back;
                    end else begin
                        state_q <= cache_pkg::refill;
                    end
                end
                cache_pkg::read_hit: begin
                    if (rd_q) begin             // array output valid now
                        cpu_r_valid <= 1'b1;
                        state_q     <= cache_pkg::idle;
                    end
                end
                cache_pkg::write_hit: begin
                    cpu_w_ready <= 1'b1;
                    state_q     <= cache_pkg::idle;
                end
                cache_pkg::write_back: begin
                    if (wb_beat && (beat_q == '1)) begin
                        state_q <= cache_pkg::refill;
                    end
                end
                cache_pkg::refill: begin
                    if (line_done) begin
                        state_q <= cache_pkg::lookup_again;
                    end
                end
                default: begin
                    state_q <= cache_pkg::idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accepting) begin
            req_addr_q <= cpu_addr;
            way_q      <= hit ? hit_way : victim_way;
        end
    end

endmodule

`default_nettype wire

// ==== src/cache_data_ram.sv ====
//##########################################################################
// cache_data_ram: line data for all ways and sets, one 64-bit word per
// entry, byte-strobed writes and registered reads
//##########################################################################
`default_nettype none

module cache_data_ram (
    input  wire logic                 clk,
    input  wire cache_pkg::way_t      ram_way,
    input  wire cache_pkg::index_t    ram_index,
    input  wire cache_pkg::word_sel_t ram_word,
    input  wire logic                 ram_r_en,
    input  wire logic                 ram_w_en,
    input  wire cache_pkg::word_t     ram_w_data,
    input  wire cache_pkg::strb_t     ram_w_strb,
    output cache_pkg::word_t          ram_r_data
);

    localparam int DEPTH =
        cache_pkg::NUM_WAYS * cache_pkg::NUM_SETS * cache_pkg::WORDS_PER_LINE;

    cache_pkg::word_t         mem_q [DEPTH];
    logic [$clog2(DEPTH)-1:0] addr;

    assign addr = {ram_way, ram_index, ram_word};  // way, set, word

    always_ff @(posedge clk) begin
        if (ram_w_en) begin
            for (int b = 0; b < cache_pkg::STRB_W; b++) begin
                if (ram_w_strb[b]) begin
                    mem_q[addr][8*b +: 8] <= ram_w_data[8*b +: 8];
                end
            end
        end
        if (ram_r_en) begin
            ram_r_data <= mem_q[addr];  // holds until the next read
        end
    end

endmodule

`default_nettype wire

// ==== src/cache_victim_lfsr.sv ====
//##########################################################################
// cache_victim_lfsr: 8-bit Fibonacci LFSR (x^8+x^6+x^5+x^4+1) and the
// victim way choice between an empty way and a random one
//##########################################################################
`default_nettype none

module cache_victim_lfsr #(
    parameter logic [7:0] VICTIM_SEED = 8'd1    // must be nonzero
) (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            set_full,
    input  wire cache_pkg::way_t empty_way,
    input  wire logic            victim_step,
    output cache_pkg::way_t      victim_way
);

    logic [7:0] lfsr_q;
    logic       feedback;

    assign feedback = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

    // set_full still shows the set before the refill's tag write lands
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr_q <= VICTIM_SEED;
        end else if (victim_step && set_full) begin
            lfsr_q <= {lfsr_q[6:0], feedback};
        end
    end

    assign victim_way = set_full ? cache_pkg::way_t'(lfsr_q[1:0]) : empty_way;

endmodule

`default_nettype wire

// ==== src/cache_tag_store.sv ====
//##########################################################################
// cache_tag_store: valid, dirty and tag bits per way and set, with
// parallel hit compare, empty-way search and victim readout
//##########################################################################
`default_nettype none

module cache_tag_store (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire cache_pkg::tag_t   lookup_tag,
    input  wire cache_pkg::index_t lookup_index,
    input  wire cache_pkg::way_t   victim_way,
    input  wire logic              tag_w_en,
    input  wire cache_pkg::way_t   tag_w_way,
    input  wire logic              tag_w_dirty,
    output logic                   hit,
    output cache_pkg::way_t        hit_way,
    output logic                   set_full,
    output cache_pkg::way_t        empty_way,
    output logic                   victim_dirty,
    output cache_pkg::tag_t        victim_tag
);

    logic [cache_pkg::NUM_SETS-1:0] valid_q [cache_pkg::NUM_WAYS];
    logic [cache_pkg::NUM_SETS-1:0] dirty_q [cache_pkg::NUM_WAYS];
    cache_pkg::tag_t                tag_q   [cache_pkg::NUM_WAYS][cache_pkg::NUM_SETS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
        end else if (tag_w_en) begin
            valid_q[tag_w_way][lookup_index] <= 1'b1; // every tag write validates
            dirty_q[tag_w_way][lookup_index] <= tag_w_dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_w_en) begin
            tag_q[tag_w_way][lookup_index] <= lookup_tag;
        end
    end

    // walk from the top way down so the lowest match and the lowest hole win
    always_comb begin
        hit       = 1'b0;
        hit_way   = '0;
        set_full  = 1'b1;
        empty_way = '0;
        for (int w = cache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (valid_q[w][lookup_index] && (tag_q[w][lookup_index] == lookup_tag)) begin
                hit     = 1'b1;
                hit_way = cache_pkg::way_t'(w);
            end
            if (!valid_q[w][lookup_index]) begin
                set_full  = 1'b0;
                empty_way = cache_pkg::way_t'(w);
            end
        end
    end

    // write-back only needed for a line that is both valid and dirty
    assign victim_dirty = valid_q[victim_way][lookup_index] & dirty_q[victim_way][lookup_index];
    assign victim_tag   = tag_q[victim_way][lookup_index];

endmodule

`default_nettype wire

// ==== src/cache_pkg.sv ====
//##########################################################################
// cache_pkg: address field widths and positions, cache geometry,
// vector typedefs, address helpers and the controller state enum
//##########################################################################
`default_nettype none

package cache_pkg;

    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 64;
    localparam int STRB_W     = WORD_W / 8;
    localparam int TAG_W      = 22;
    localparam int INDEX_W    = 4;
    localparam int WORD_SEL_W = 3;
    localparam int WAY_W      = 2;

    localparam int WORD_LSB  = 3;                   // bits 2:0 ignored
    localparam int INDEX_LSB = WORD_LSB + WORD_SEL_W; // also the line offset width
    localparam int TAG_LSB   = INDEX_LSB + INDEX_W;

    localparam int NUM_WAYS       = 4;
    localparam int NUM_SETS       = 16;
    localparam int WORDS_PER_LINE = 8;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [STRB_W-1:0]     strb_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [WORD_SEL_W-1:0] word_sel_t;
    typedef logic [WAY_W-1:0]      way_t;

    typedef enum logic [2:0] {
        idle,
        read_hit,
        write_hit,
        write_back,
        refill,
        lookup_again      // replays the held request after a refill
    } ctrl_state_t;

    function automatic tag_t addr_tag(addr_t a);
        return a[TAG_LSB +: TAG_W];
    endfunction

    function automatic index_t addr_index(addr_t a);
        return a[INDEX_LSB +: INDEX_W];
    endfunction

    function automatic word_sel_t addr_word(addr_t a);
        return a[WORD_LSB +: WORD_SEL_W];
    endfunction

    // byte address of word 0 of a line
    function automatic addr_t line_addr(tag_t t, index_t i);
        return {t, i, {INDEX_LSB{1'b0}}};
    endfunction

endpackage

`default_nettype wire
